// File: sources.f
hw/dcache_axi_pkg.sv
hw/dcache_req_if.sv
hw/dcache_req_latch.sv
hw/axi_wr_burst.sv
hw/axi_rd_burst.sv
hw/dcache_axi_top.sv
tests/axi_mem_model.sv
tests/tb_dcache_axi.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dcache_axi -f sources.f -o tb_dcache_axi \
    && ./obj_dir/tb_dcache_axi | tee /dev/stderr | grep -qxF '*** PASSED ***' \
    && { echo "simulation run ok"; exit 0; } \
    || { echo "simulation run not ok"; exit 1; }

// File: tests/tb_dcache_axi.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dcache_axi;

    localparam int ADDR_WIDTH     = 32;
    localparam int NUM_ENTRIES    = 13;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (4 + 40) * 2;
    localparam logic [1:0] KIND_WR    = 2'd0;  // write, wait for the response
    localparam logic [1:0] KIND_RD    = 2'd1;
    localparam logic [1:0] KIND_WR_BG = 2'd2;  // write left running under the next read

    logic                  clock;
    logic                  reset;
    logic                  wr_valid, wr_ready, rd_valid, rd_ready;
    logic [ADDR_WIDTH-1:0] wr_addr, rd_addr;
    logic [255:0]          wr_line;
    logic [7:0]            wr_len, wr_mask, rd_len;
    logic [2:0]            wr_size;
    logic [63:0]           data_read;
    logic                  data_valid, rd_last;
    logic                  aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    logic                  ar_valid, ar_ready, r_valid, r_ready, r_last;
    logic [ADDR_WIDTH-1:0] aw_addr, ar_addr;
    logic [63:0]           w_data, r_data;
    logic [7:0]            w_strb, ar_len, aw_len;
    logic [2:0]            aw_size, ar_size, aw_prot, ar_prot;
    logic [1:0]            aw_burst, ar_burst;
    logic [3:0]            aw_id, ar_id, aw_cache, ar_cache;
    logic [3:0]            aw_qos, ar_qos, aw_region, ar_region;
    logic                  aw_user, ar_user, w_user, aw_lock, ar_lock;

    logic [1:0]            tbl_kind [NUM_ENTRIES];
    logic [ADDR_WIDTH-1:0] tbl_addr [NUM_ENTRIES];
    logic [7:0]            tbl_len  [NUM_ENTRIES];
    logic [2:0]            tbl_size [NUM_ENTRIES];
    logic [7:0]            tbl_mask [NUM_ENTRIES];
    logic [63:0]           tbl_pat  [NUM_ENTRIES];
    logic [63:0]           shadow [0:255];  // expected memory, one word per beat address
    int                    num_entries = 0;
    int                    wr_entry = 0;    // table entry of the write in flight
    int                    errors = 0;
    int                    cycles = 0;

    dcache_axi_top #(.ADDR_WIDTH(ADDR_WIDTH), .AXI_ID_WIDTH(4)) dut_i (
        .clock(clock), .reset(reset),
        .wr_valid_i(wr_valid), .wr_ready_o(wr_ready), .wr_addr_i(wr_addr),
        .wr_line_i(wr_line), .wr_len_i(wr_len), .wr_size_i(wr_size), .wr_mask_i(wr_mask),
        .rd_valid_i(rd_valid), .rd_ready_o(rd_ready), .rd_addr_i(rd_addr), .rd_len_i(rd_len),
        .data_read_o(data_read), .data_valid_o(data_valid), .rd_last_o(rd_last),
        .axi_aw_ready_i(aw_ready), .axi_aw_valid_o(aw_valid), .axi_aw_addr_o(aw_addr),
        .axi_aw_prot_o(aw_prot), .axi_aw_id_o(aw_id), .axi_aw_user_o(aw_user),
        .axi_aw_len_o(aw_len), .axi_aw_size_o(aw_size), .axi_aw_burst_o(aw_burst),
        .axi_aw_lock_o(aw_lock), .axi_aw_cache_o(aw_cache), .axi_aw_qos_o(aw_qos),
        .axi_aw_region_o(aw_region),
        .axi_w_ready_i(w_ready), .axi_w_valid_o(w_valid), .axi_w_data_o(w_data),
        .axi_w_strb_o(w_strb), .axi_w_last_o(w_last), .axi_w_user_o(w_user),
        .axi_b_ready_o(b_ready),
        .axi_b_valid_i(b_valid), .axi_b_resp_i(2'b00), .axi_b_id_i(4'd1), .axi_b_user_i(1'b0),
        .axi_ar_ready_i(ar_ready), .axi_ar_valid_o(ar_valid), .axi_ar_addr_o(ar_addr),
        .axi_ar_prot_o(ar_prot), .axi_ar_id_o(ar_id), .axi_ar_user_o(ar_user),
        .axi_ar_len_o(ar_len), .axi_ar_size_o(ar_size), .axi_ar_burst_o(ar_burst),
        .axi_ar_lock_o(ar_lock), .axi_ar_cache_o(ar_cache), .axi_ar_qos_o(ar_qos),
        .axi_ar_region_o(ar_region),
        .axi_r_ready_o(r_ready), .axi_r_valid_i(r_valid),
        .axi_r_resp_i(2'b00), .axi_r_data_i(r_data), .axi_r_last_i(r_last),
        .axi_r_id_i(4'd1), .axi_r_user_i(1'b0)
    );

    axi_mem_model #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (
        .clock(clock), .reset(reset),
        .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_ready_o(aw_ready),
        .w_valid_i(w_valid), .w_data_i(w_data), .w_strb_i(w_strb), .w_last_i(w_last),
        .w_ready_o(w_ready), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_len_i(ar_len), .ar_ready_o(ar_ready),
        .r_valid_o(r_valid), .r_data_o(r_data), .r_last_o(r_last), .r_ready_i(r_ready)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a burst never completed", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // burst length and size checked on the edge that takes the address
    always @(posedge clock) begin
        if (reset && aw_valid && aw_ready) begin
            check_value(64'(aw_len), 64'(tbl_len[wr_entry]),
                        $sformatf("entry %0d aw_len", wr_entry));
            check_value(64'(aw_size), 64'(tbl_size[wr_entry]),
                        $sformatf("entry %0d aw_size", wr_entry));
        end
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_entry(input logic [1:0] kind, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [7:0] len, input logic [2:0] size,
                             input logic [7:0] mask, input logic [63:0] pat);
        tbl_kind[num_entries] = kind;
        tbl_addr[num_entries] = addr;
        tbl_len[num_entries]  = len;
        tbl_size[num_entries] = size;
        tbl_mask[num_entries] = mask;
        tbl_pat[num_entries]  = pat;
        num_entries++;
    endtask

    // four distinct beats from one pattern
    function automatic logic [255:0] make_line(input logic [63:0] pat);
        logic [255:0] line;
        for (int k = 0; k < 4; k++) begin
            line[k*64 +: 64] = pat ^ (64'h0101_0101_0101_0101 * 64'(k + 1));
        end
        return line;
    endfunction

    task automatic wait_write_idle();
        @(posedge clock);
        while (!wr_ready) @(posedge clock);
    endtask

    task automatic run_write(input int n);
        logic [255:0] line;
        logic [7:0]   base;
        line     = make_line(tbl_pat[n]);
        base     = tbl_addr[n][10:3];
        wr_entry = n;
        @(negedge clock);
        wr_valid = 1'b1;
        wr_addr  = tbl_addr[n];
        wr_line  = line;
        wr_len   = tbl_len[n];
        wr_size  = tbl_size[n];
        wr_mask  = tbl_mask[n];
        @(posedge clock);
        while (!wr_ready) @(posedge clock);
        @(negedge clock);
        wr_valid = 1'b0;
        // same byte mask on every beat
        for (int k = 0; k <= int'(tbl_len[n]); k++) begin
            for (int b = 0; b < 8; b++) begin
                if (tbl_mask[n][b]) begin
                    shadow[base + 8'(k)][b*8 +: 8] = line[k*64 + b*8 +: 8];
                end
            end
        end
        if (tbl_kind[n] == KIND_WR) wait_write_idle();
    endtask

    task automatic run_read(input int n);
        logic [7:0] base;
        logic       done;
        int         beats;
        base  = tbl_addr[n][10:3];
        beats = 0;
        done  = 1'b0;
        @(negedge clock);
        rd_valid = 1'b1;
        rd_addr  = tbl_addr[n];
        rd_len   = tbl_len[n];
        @(posedge clock);
        while (!rd_ready) @(posedge clock);
        @(negedge clock);
        rd_valid = 1'b0;
        while (!done) begin
            @(posedge clock);  // beats sampled on the edge that takes them
            if (data_valid) begin
                check_value(data_read, shadow[base + 8'(beats)],
                            $sformatf("entry %0d beat %0d data", n, beats));
                check_value(64'(rd_last), 64'(beats == int'(tbl_len[n])),
                            $sformatf("entry %0d beat %0d rd_last", n, beats));
                beats++;
                done = rd_last;
            end
        end
        check_value(64'(beats), 64'(tbl_len[n]) + 64'd1, $sformatf("entry %0d beat count", n));
        @(posedge clock);
        check_value(64'(rd_ready), 64'd1, $sformatf("entry %0d rd_ready after burst", n));
    endtask

    initial begin
        clock    = 1'b0;
        reset    = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_line  = '0;
        wr_len   = 8'd0;
        wr_size  = 3'd0;
        wr_mask  = 8'd0;
        rd_valid = 1'b0;
        rd_addr  = '0;
        rd_len   = 8'd0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = {8{8'(i)}};  // same fill as the memory model
        end
        // kind, address, len, size, mask, line pattern
        add_entry(KIND_WR,    32'h000, 8'd3, 3'd3, 8'hFF, 64'h0123_4567_89AB_CDEF);
        add_entry(KIND_RD,    32'h000, 8'd3, 3'd3, 8'h00, 64'h0);
        add_entry(KIND_WR,    32'h100, 8'd3, 3'd3, 8'hFF, 64'hFEDC_BA98_7654_3210);
        add_entry(KIND_WR,    32'h100, 8'd3, 3'd3, 8'h0F, 64'h5A5A_A5A5_3C3C_C3C3);
        add_entry(KIND_RD,    32'h100, 8'd3, 3'd3, 8'h00, 64'h0);
        add_entry(KIND_WR,    32'h200, 8'd0, 3'd3, 8'hFF, 64'h1111_2222_3333_4444);
        add_entry(KIND_RD,    32'h200, 8'd1, 3'd3, 8'h00, 64'h0);  // neighbour beat untouched
        add_entry(KIND_RD,    32'h200, 8'd0, 3'd3, 8'h00, 64'h0);
        add_entry(KIND_WR_BG, 32'h300, 8'd3, 3'd3, 8'hFF, 64'hDEAD_BEEF_CAFE_F00D);
        add_entry(KIND_RD,    32'h000, 8'd3, 3'd3, 8'h00, 64'h0);  // overlaps the write above
        add_entry(KIND_RD,    32'h300, 8'd3, 3'd3, 8'h00, 64'h0);
        add_entry(KIND_WR,    32'h040, 8'd2, 3'd3, 8'hA5, 64'h0F1E_2D3C_4B5A_6978);
        add_entry(KIND_RD,    32'h040, 8'd3, 3'd3, 8'h00, 64'h0);
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(posedge clock);
        check_value(64'({aw_valid, w_valid, b_ready, ar_valid, r_ready, data_valid, rd_last}),
                    64'd0, "valid outputs after reset");
        check_value(64'({wr_ready, rd_ready}), 64'd3, "ready outputs after reset");
        // INCR bursts of 8-byte beats, data access, ids fixed at 1
        check_value(64'({aw_burst, ar_burst, ar_size, aw_prot, ar_prot}),
                    64'({2'b01, 2'b01, 3'd3, 3'd0, 3'd0}), "burst, size and prot tie-offs");
        check_value(64'({aw_id, ar_id, aw_cache, ar_cache}),
                    64'({4'd1, 4'd1, 4'hF, 4'h0}), "id and cache tie-offs");
        check_value(64'({aw_qos, ar_qos, aw_region, ar_region}), 64'd0, "qos and region tie-offs");
        check_value(64'({aw_lock, ar_lock, aw_user, ar_user, w_user}), 64'd0,
                    "lock and user tie-offs");
        for (int n = 0; n < num_entries; n++) begin
            if (tbl_kind[n] == KIND_RD) begin
                run_read(n);
                wait_write_idle();
            end else begin
                run_write(n);
            end
        end
        $display("run done: %0d entries, %0d errors", num_entries, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/axi_mem_model.sv
`default_nettype none
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int ADDR_WIDTH = 32
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  aw_valid_i,
    input  wire [ADDR_WIDTH-1:0] aw_addr_i,
    output logic                 aw_ready_o,
    input  wire                  w_valid_i,
    input  wire [63:0]           w_data_i,
    input  wire [7:0]            w_strb_i,
    input  wire                  w_last_i,
    output logic                 w_ready_o,
    output logic                 b_valid_o,
    input  wire                  b_ready_i,
    input  wire                  ar_valid_i,
    input  wire [ADDR_WIDTH-1:0] ar_addr_i,
    input  wire [7:0]            ar_len_i,
    output logic                 ar_ready_o,
    output logic                 r_valid_o,
    output logic [63:0]          r_data_o,
    output logic                 r_last_o,
    input  wire                  r_ready_i
);

    logic [63:0] mem [0:255];  // one word per beat address
    logic [7:0]  w_ptr;
    logic [7:0]  r_ptr;
    logic [7:0]  r_left;       // beats still to return after the current one
    logic        r_active;
    logic        r_taken;      // beat handshaken at the last rising edge
    logic        b_pending;
    logic [31:0] lcg_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8{8'(i)}};
        end
    end

    // handshakes are taken on the rising edge
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_ptr     <= 8'd0;
            r_ptr     <= 8'd0;
            r_left    <= 8'd0;
            r_active  <= 1'b0;
            r_taken   <= 1'b0;
            b_pending <= 1'b0;
        end else begin
            r_taken <= r_valid_o && r_ready_i;
            if (aw_valid_i && aw_ready_o) begin
                w_ptr <= aw_addr_i[10:3];
            end
            if (w_valid_i && w_ready_o) begin
                for (int b = 0; b < 8; b++) begin
                    if (w_strb_i[b]) begin
                        mem[w_ptr][b*8 +: 8] = w_data_i[b*8 +: 8];
                    end
                end
                w_ptr <= w_ptr + 8'd1;
                if (w_last_i) b_pending <= 1'b1;
            end
            if (b_valid_o && b_ready_i) b_pending <= 1'b0;
            if (ar_valid_i && ar_ready_o) begin
                r_ptr    <= ar_addr_i[10:3];
                r_left   <= ar_len_i;
                r_active <= 1'b1;
            end
            if (r_valid_o && r_ready_i) begin
                r_ptr  <= r_ptr + 8'd1;
                r_left <= r_left - 8'd1;
                if (r_last_o) r_active <= 1'b0;
            end
        end
    end

    // outputs change on the falling edge, stalls from the LCG
    always @(negedge clock or negedge reset) begin
        if (!reset) begin
            lcg_state  <= 32'h9380;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            ar_ready_o <= 1'b0;
            b_valid_o  <= 1'b0;
            r_valid_o  <= 1'b0;
            r_data_o   <= 64'd0;
            r_last_o   <= 1'b0;
        end else begin
            lcg_state  <= lcg_next(lcg_state);
            aw_ready_o <= (lcg_state[17:16] != 2'b00);  // ready three cycles in four
            w_ready_o  <= (lcg_state[19:18] != 2'b00);
            ar_ready_o <= (lcg_state[21:20] != 2'b00);
            b_valid_o  <= b_pending && (b_valid_o || lcg_state[22]);
            // a presented beat holds until it is taken
            if (!r_valid_o || r_taken) begin
                r_valid_o <= r_active && (lcg_state[25:24] != 2'b00);
                r_data_o  <= mem[r_ptr];
                r_last_o  <= (r_left == 8'd0);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_axi_top.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_axi_top #(
    parameter int ADDR_WIDTH   = 64,
    parameter int AXI_ID_WIDTH = 4
) (
    input  wire                                   clock,
    input  wire                                   reset,
    // cache side
    input  wire                                   wr_valid_i,
    output logic                                  wr_ready_o,
    input  wire  [ADDR_WIDTH-1:0]                 wr_addr_i,
    input  wire  [dcache_axi_pkg::LINE_WIDTH-1:0] wr_line_i,
    input  wire  [7:0]                            wr_len_i,
    input  wire  [2:0]                            wr_size_i,
    input  wire  [dcache_axi_pkg::STRB_WIDTH-1:0] wr_mask_i,
    input  wire                                   rd_valid_i,
    output logic                                  rd_ready_o,
    input  wire  [ADDR_WIDTH-1:0]                 rd_addr_i,
    input  wire  [7:0]                            rd_len_i,
    output logic [dcache_axi_pkg::BEAT_WIDTH-1:0] data_read_o,
    output logic                                  data_valid_o,
    output logic                                  rd_last_o,
    // AXI write address
    input  wire                                   axi_aw_ready_i,
    output logic                                  axi_aw_valid_o,
    output logic [ADDR_WIDTH-1:0]                 axi_aw_addr_o,
    output logic [2:0]                            axi_aw_prot_o,
    output logic [AXI_ID_WIDTH-1:0]               axi_aw_id_o,
    output logic                                  axi_aw_user_o,
    output logic [7:0]                            axi_aw_len_o,
    output logic [2:0]                            axi_aw_size_o,
    output logic [1:0]                            axi_aw_burst_o,
    output logic                                  axi_aw_lock_o,
    output logic [3:0]                            axi_aw_cache_o,
    output logic [3:0]                            axi_aw_qos_o,
    output logic [3:0]                            axi_aw_region_o,
    // AXI write data and response
    input  wire                                   axi_w_ready_i,
    output logic                                  axi_w_valid_o,
    output logic [dcache_axi_pkg::BEAT_WIDTH-1:0] axi_w_data_o,
    output logic [dcache_axi_pkg::STRB_WIDTH-1:0] axi_w_strb_o,
    output logic                                  axi_w_last_o,
    output logic                                  axi_w_user_o,
    output logic                                  axi_b_ready_o,
    input  wire                                   axi_b_valid_i,
    input  wire  [1:0]                            axi_b_resp_i,
    input  wire  [AXI_ID_WIDTH-1:0]               axi_b_id_i,
    input  wire                                   axi_b_user_i,
    // AXI read address
    input  wire                                   axi_ar_ready_i,
    output logic                                  axi_ar_valid_o,
    output logic [ADDR_WIDTH-1:0]                 axi_ar_addr_o,
    output logic [2:0]                            axi_ar_prot_o,
    output logic [AXI_ID_WIDTH-1:0]               axi_ar_id_o,
    output logic                                  axi_ar_user_o,
    output logic [7:0]                            axi_ar_len_o,
    output logic [2:0]                            axi_ar_size_o,
    output logic [1:0]                            axi_ar_burst_o,
    output logic                                  axi_ar_lock_o,
    output logic [3:0]                            axi_ar_cache_o,
    output logic [3:0]                            axi_ar_qos_o,
    output logic [3:0]                            axi_ar_region_o,
    // AXI read data
    output logic                                  axi_r_ready_o,
    input  wire                                   axi_r_valid_i,
    input  wire  [1:0]                            axi_r_resp_i,
    input  wire  [dcache_axi_pkg::BEAT_WIDTH-1:0] axi_r_data_i,
    input  wire                                   axi_r_last_i,
    input  wire  [AXI_ID_WIDTH-1:0]               axi_r_id_i,
    input  wire                                   axi_r_user_i
);

    wr_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) wr_req ();
    rd_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) rd_req ();

    dcache_req_latch #(.ADDR_WIDTH(ADDR_WIDTH)) u_latch (
        .clock(clock), .reset(reset),
        .wr_valid_i(wr_valid_i), .wr_addr_i(wr_addr_i), .wr_line_i(wr_line_i),
        .wr_len_i(wr_len_i), .wr_size_i(wr_size_i), .wr_mask_i(wr_mask_i),
        .rd_valid_i(rd_valid_i), .rd_addr_i(rd_addr_i), .rd_len_i(rd_len_i),
        .wr_ready_o(wr_ready_o), .rd_ready_o(rd_ready_o),
        .wr_o(wr_req.latch), .rd_o(rd_req.latch)
    );

    axi_wr_burst #(.ADDR_WIDTH(ADDR_WIDTH)) u_wr_burst (
        .clock(clock), .reset(reset), .req_i(wr_req.engine),
        .aw_ready_i(axi_aw_ready_i), .w_ready_i(axi_w_ready_i), .b_valid_i(axi_b_valid_i),
        .aw_valid_o(axi_aw_valid_o), .aw_addr_o(axi_aw_addr_o),
        .aw_len_o(axi_aw_len_o), .aw_size_o(axi_aw_size_o),
        .w_valid_o(axi_w_valid_o), .w_data_o(axi_w_data_o), .w_strb_o(axi_w_strb_o),
        .w_last_o(axi_w_last_o), .b_ready_o(axi_b_ready_o)
    );

    axi_rd_burst #(.ADDR_WIDTH(ADDR_WIDTH)) u_rd_burst (
        .clock(clock), .reset(reset), .req_i(rd_req.engine),
        .ar_ready_i(axi_ar_ready_i), .r_valid_i(axi_r_valid_i),
        .r_last_i(axi_r_last_i), .r_data_i(axi_r_data_i),
        .ar_valid_o(axi_ar_valid_o), .ar_addr_o(axi_ar_addr_o), .ar_len_o(axi_ar_len_o),
        .r_ready_o(axi_r_ready_o), .data_read_o(data_read_o),
        .data_valid_o(data_valid_o), .rd_last_o(rd_last_o)
    );

    // fixed attributes, ids and user fields
    assign axi_aw_prot_o   = dcache_axi_pkg::AXI_PROT_DATA;
    assign axi_aw_id_o     = AXI_ID_WIDTH'(1);
    assign axi_aw_user_o   = 1'b0;
    assign axi_aw_burst_o  = dcache_axi_pkg::AXI_BURST_INCR;
    assign axi_aw_lock_o   = 1'b0;
    assign axi_aw_cache_o  = dcache_axi_pkg::AXI_AWCACHE_WB_ALLOC;
    assign axi_aw_qos_o    = 4'h0;
    assign axi_aw_region_o = 4'h0;
    assign axi_w_user_o    = 1'b0;

    assign axi_ar_prot_o   = dcache_axi_pkg::AXI_PROT_DATA;
    assign axi_ar_id_o     = AXI_ID_WIDTH'(1);
    assign axi_ar_user_o   = 1'b0;
    assign axi_ar_size_o   = 3'($clog2(dcache_axi_pkg::STRB_WIDTH));  // full-width beats
    assign axi_ar_burst_o  = dcache_axi_pkg::AXI_BURST_INCR;
    assign axi_ar_lock_o   = 1'b0;
    assign axi_ar_cache_o  = dcache_axi_pkg::AXI_ARCACHE_NONCACHE;
    assign axi_ar_qos_o    = 4'h0;
    assign axi_ar_region_o = 4'h0;

endmodule

`default_nettype wire

// File: hw/axi_rd_burst.sv
`default_nettype none
`timescale 1ns/1ps

module axi_rd_burst #(
    parameter int ADDR_WIDTH = 64
) (
    input  wire                                   clock,
    input  wire                                   reset,
    rd_req_if.engine                              req_i,
    input  wire                                   ar_ready_i,
    input  wire                                   r_valid_i,
    input  wire                                   r_last_i,
    input  wire  [dcache_axi_pkg::BEAT_WIDTH-1:0] r_data_i,
    output logic                                  ar_valid_o,
    output logic [ADDR_WIDTH-1:0]                 ar_addr_o,
    output logic [7:0]                            ar_len_o,
    output logic                                  r_ready_o,
    output logic [dcache_axi_pkg::BEAT_WIDTH-1:0] data_read_o,
    output logic                                  data_valid_o,
    output logic                                  rd_last_o
);

    dcache_axi_pkg::rd_state_e state_q;
    dcache_axi_pkg::rd_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_axi_pkg::rd_idle:    if (req_i.start) state_d = dcache_axi_pkg::rd_ar_wait;
            dcache_axi_pkg::rd_ar_wait: if (ar_ready_i) state_d = dcache_axi_pkg::rd_r_recv;
            dcache_axi_pkg::rd_r_recv:  if (rd_last_o) state_d = dcache_axi_pkg::rd_idle;
            default:                    state_d = dcache_axi_pkg::rd_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= dcache_axi_pkg::rd_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign req_i.idle = (state_q == dcache_axi_pkg::rd_idle);

    assign ar_valid_o = (state_q == dcache_axi_pkg::rd_ar_wait);
    assign ar_addr_o  = req_i.addr;
    assign ar_len_o   = req_i.len;

    assign r_ready_o    = (state_q == dcache_axi_pkg::rd_r_recv);
    assign data_read_o  = r_data_i;               // same-cycle forward
    assign data_valid_o = r_valid_i && r_ready_o;
    assign rd_last_o    = data_valid_o && r_last_i;  // burst ends on a taken last beat

    a_ar_hold: assert property (
        @(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o)
    ) else $error("ar_valid dropped or address changed before ar_ready");

endmodule

`default_nettype wire

// File: hw/axi_wr_burst.sv
`default_nettype none
`timescale 1ns/1ps

module axi_wr_burst #(
    parameter int ADDR_WIDTH = 64
) (
    input  wire                                  clock,
    input  wire                                  reset,
    wr_req_if.engine                             req_i,
    input  wire                                  aw_ready_i,
    input  wire                                  w_ready_i,
    input  wire                                  b_valid_i,
    output logic                                 aw_valid_o,
    output logic [ADDR_WIDTH-1:0]                aw_addr_o,
    output logic [7:0]                           aw_len_o,
    output logic [2:0]                           aw_size_o,
    output logic                                 w_valid_o,
    output logic [dcache_axi_pkg::BEAT_WIDTH-1:0] w_data_o,
    output logic [dcache_axi_pkg::STRB_WIDTH-1:0] w_strb_o,
    output logic                                 w_last_o,
    output logic                                 b_ready_o
);

    dcache_axi_pkg::wr_state_e state_q;
    dcache_axi_pkg::wr_state_e state_d;
    logic [1:0]                beat_cnt_q;
    logic                      last_beat;

    assign last_beat = (state_q == dcache_axi_pkg::wr_w_send) &&
                       (req_i.len == {6'd0, beat_cnt_q});

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_axi_pkg::wr_idle:    if (req_i.start) state_d = dcache_axi_pkg::wr_aw_wait;
            dcache_axi_pkg::wr_aw_wait: if (aw_ready_i) state_d = dcache_axi_pkg::wr_w_send;
            dcache_axi_pkg::wr_w_send:  if (w_ready_i && last_beat) begin
                state_d = dcache_axi_pkg::wr_b_wait;
            end
            dcache_axi_pkg::wr_b_wait:  if (b_valid_i) state_d = dcache_axi_pkg::wr_idle;
            default:                    state_d = dcache_axi_pkg::wr_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= dcache_axi_pkg::wr_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // beat index into the line, holds while w_ready is low
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            beat_cnt_q <= 2'd0;
        end else if (req_i.start) begin
            beat_cnt_q <= 2'd0;
        end else if (w_valid_o && w_ready_i && !last_beat) begin
            beat_cnt_q <= beat_cnt_q + 2'd1;
        end
    end

    assign req_i.idle = (state_q == dcache_axi_pkg::wr_idle);

    assign aw_valid_o = (state_q == dcache_axi_pkg::wr_aw_wait);
    assign aw_addr_o  = req_i.addr;
    assign aw_len_o   = req_i.len;
    assign aw_size_o  = req_i.size;

    assign w_valid_o = (state_q == dcache_axi_pkg::wr_w_send);
    assign w_data_o  = req_i.line.beat[beat_cnt_q];
    assign w_strb_o  = req_i.mask;   // one mask for all beats
    assign w_last_o  = last_beat;

    assign b_ready_o = (state_q == dcache_axi_pkg::wr_b_wait);

    a_aw_hold: assert property (
        @(posedge clock) disable iff (!reset)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o)
    ) else $error("aw_valid dropped or address changed before aw_ready");

    // a waiting beat keeps its data and last flag
    a_w_hold: assert property (
        @(posedge clock) disable iff (!reset)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_last_o)
    ) else $error("w beat or w_last changed before w_ready");

endmodule

`default_nettype wire

// File: hw/dcache_req_latch.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_req_latch #(
    parameter int ADDR_WIDTH = 64
) (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire                                  wr_valid_i,
    input  wire [ADDR_WIDTH-1:0]                 wr_addr_i,
    input  wire [dcache_axi_pkg::LINE_WIDTH-1:0] wr_line_i,
    input  wire [7:0]                            wr_len_i,
    input  wire [2:0]                            wr_size_i,
    input  wire [dcache_axi_pkg::STRB_WIDTH-1:0] wr_mask_i,
    input  wire                                  rd_valid_i,
    input  wire [ADDR_WIDTH-1:0]                 rd_addr_i,
    input  wire [7:0]                            rd_len_i,
    output logic                                 wr_ready_o,
    output logic                                 rd_ready_o,
    wr_req_if.latch                              wr_o,
    rd_req_if.latch                              rd_o
);

    logic wr_accept;
    logic rd_accept;

    // a request is taken only while its engine sits idle
    assign wr_accept = wr_valid_i && wr_o.idle;
    assign rd_accept = rd_valid_i && rd_o.idle;

    assign wr_ready_o = wr_o.idle;
    assign rd_ready_o = rd_o.idle;

    // engine leaves idle on the accept edge
    assign wr_o.start = wr_accept;
    assign rd_o.start = rd_accept;

    // line and mask captured together with the address
    always_ff @(posedge clock) begin
        if (wr_accept) begin
            wr_o.addr     <= wr_addr_i;
            wr_o.line.raw <= wr_line_i;
            wr_o.len      <= wr_len_i;
            wr_o.size     <= wr_size_i;
            wr_o.mask     <= wr_mask_i;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_accept) begin
            rd_o.addr <= rd_addr_i;
            rd_o.len  <= rd_len_i;
        end
    end

    // the write counter wraps at four, a longer burst would never see last
    a_wr_len_fits_line: assert property (
        @(posedge clock) disable iff (!reset)
        wr_accept |-> (wr_len_i < 8'(dcache_axi_pkg::BEATS_PER_LINE))
    ) else $error("write burst longer than one cache line");

endmodule

`default_nettype wire

// File: hw/dcache_req_if.sv
`default_nettype none
`timescale 1ns/1ps

interface wr_req_if #(
    parameter int ADDR_WIDTH = 64
);
    logic                                  start;  // one cycle, on accept
    logic [ADDR_WIDTH-1:0]                 addr;
    dcache_axi_pkg::cache_line_u           line;
    logic [7:0]                            len;    // beats minus one
    logic [2:0]                            size;
    logic [dcache_axi_pkg::STRB_WIDTH-1:0] mask;   // same strobe on every beat
    logic                                  idle;

    modport latch (output start, addr, line, len, size, mask, input idle);
    modport engine (input start, addr, line, len, size, mask, output idle);
endinterface

interface rd_req_if #(
    parameter int ADDR_WIDTH = 64
);
    logic                  start;
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;
    logic                  idle;

    modport latch (output start, addr, len, input idle);
    modport engine (input start, addr, len, output idle);
endinterface

`default_nettype wire

// File: hw/dcache_axi_pkg.sv
`default_nettype none

package dcache_axi_pkg;

    localparam int BEAT_WIDTH     = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_WIDTH     = BEAT_WIDTH * BEATS_PER_LINE;  // 256
    localparam int STRB_WIDTH     = BEAT_WIDTH / 8;

    // whole line on capture, beat view on the W channel
    typedef union packed {
        logic [LINE_WIDTH-1:0]                     raw;
        logic [BEATS_PER_LINE-1:0][BEAT_WIDTH-1:0] beat;  // beat 0 in low bits
    } cache_line_u;

    // attribute codes for the top level tie-offs
    localparam logic [1:0] AXI_BURST_INCR       = 2'b01;
    localparam logic [2:0] AXI_PROT_DATA        = 3'b000;  // unprivileged, secure, data
    localparam logic [3:0] AXI_AWCACHE_WB_ALLOC = 4'b1111;
    localparam logic [3:0] AXI_ARCACHE_NONCACHE = 4'b0000;

    typedef enum logic [1:0] {
        wr_idle    = 2'b00,
        wr_aw_wait = 2'b01,
        wr_w_send  = 2'b11,
        wr_b_wait  = 2'b10
    } wr_state_e;

    typedef enum logic [1:0] {
        rd_idle    = 2'b00,
        rd_ar_wait = 2'b01,
        rd_r_recv  = 2'b11
    } rd_state_e;

endpackage

`default_nettype wire
